// File: include/cpu_macros.svh
//////////////////////////////////////////////////
// Core width and register file parameters
//////////////////////////////////////////////////
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width
`define CPU_DATA_W   16
// Register file geometry
`define CPU_REG_N    32
`define CPU_REG_AW   5
// JI and J write their return address here
`define CPU_LINK_REG 16
// WAIT count field
`define CPU_WAIT_W   11

`endif

// File: src/isa_pkg.sv
//////////////////////////////////////////////////
// ISA encodings: opcodes, ALU operations,
// branch conditions and instruction fields
//////////////////////////////////////////////////
`include "cpu_macros.svh"

package isa_pkg;

	// Primary opcode, instr[15:11]
	// ALU ops keep their alu_op_e code in bits 13..11
	typedef enum logic [4:0] {
		OP_ADD  = 5'b00000,
		OP_SUB  = 5'b00001,
		OP_AND  = 5'b00010,
		OP_OR   = 5'b00011,
		OP_SLL  = 5'b00100,
		OP_SR   = 5'b00101,
		OP_ADDI = 5'b01000,
		OP_LDL  = 5'b10000,
		OP_LDU  = 5'b10001,
		OP_LD   = 5'b10010,
		OP_ST   = 5'b10011,
		OP_B    = 5'b11000,
		OP_J    = 5'b11001,
		OP_JI   = 5'b11010,
		OP_WAIT = 5'b11100,
		OP_NOP  = 5'b11110,
		OP_HLT  = 5'b11111
	} opcode_e;

	// ALU function, instr[13:11]
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLL = 3'd4,
		ALU_SR  = 3'd5
	} alu_op_e;

	// Branch condition, instr[10:8]
	typedef enum logic [2:0] {
		COND_EQ = 3'd0,
		COND_NE = 3'd1,
		COND_GT = 3'd2,
		COND_LT = 3'd3,
		COND_GE = 3'd4,
		COND_LE = 3'd5,
		COND_OV = 3'd6,
		COND_AL = 3'd7
	} cond_e;

	// Register format; other formats reuse the low 11 bits:
	//   ADDI imm5 in rt, LDL/LDU reg in [10:8] and imm8 in [7:0],
	//   B cond in [10:8] and offset in [7:0], JI target and WAIT count in [10:0]
	typedef struct packed {
		opcode_e                opcode;
		logic                   x_bit;
		logic [`CPU_REG_AW-1:0] rd;
		logic [`CPU_REG_AW-1:0] rt;
	} instr_t;

endpackage

// File: src/pipe_pkg.sv
//////////////////////////////////////////////////
// Flag and decoded control types of the pipeline
//////////////////////////////////////////////////
package pipe_pkg;

	typedef struct packed {
		logic z;
		logic n;
		logic v;
	} flags_t;

	typedef struct packed {
		// Result source select
		logic alu_to_reg;
		logic pcr_to_reg;
		logic mem_to_reg;
		logic imm_to_reg;
		// Register file and memory enables
		logic we_dst_0;
		logic we_dst_1;
		logic mem_we;
		logic mem_re;
		logic halt;
		// Execute controls
		logic add_immd;
		logic jump_immd;
		logic ldu;
		logic ldl;
		logic branch;
		logic jump;
		// Flag write enables
		logic z_we;
		logic n_we;
		logic v_we;
	} ctrl_t;

endpackage

// File: src/cpu_ifs.sv
//////////////////////////////////////////////////
// DEX pipeline bundle and register write-back
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_macros.svh"

interface dex_if
	import pipe_pkg::*;
();
	ctrl_t                  ctrl;
	logic [`CPU_REG_AW-1:0] dst_addr_0;
	logic [`CPU_REG_AW-1:0] dst_addr_1;
	logic [`CPU_DATA_W-1:0] alu_result;
	logic [`CPU_DATA_W-1:0] pc_return;
	logic [`CPU_DATA_W-1:0] mem_addr;
	logic [`CPU_DATA_W-1:0] mem_wdata;
	logic [`CPU_DATA_W-1:0] load_immd;
	logic [`CPU_DATA_W-1:0] reg_data_0;

	modport stage (output ctrl, dst_addr_0, dst_addr_1, alu_result, pc_return,
		mem_addr, mem_wdata, load_immd, reg_data_0);
	modport sink (input ctrl, dst_addr_0, dst_addr_1, alu_result, pc_return,
		mem_addr, mem_wdata, load_immd, reg_data_0);
endinterface

// Two register file write ports, applied at the next edge
interface wb_if;
	logic                   we_0;
	logic [`CPU_REG_AW-1:0] addr_0;
	logic [`CPU_DATA_W-1:0] data_0;
	logic                   we_1;
	logic [`CPU_REG_AW-1:0] addr_1;
	logic [`CPU_DATA_W-1:0] data_1;

	modport source (output we_0, addr_0, data_0, we_1, addr_1, data_1);
	modport sink (input we_0, addr_0, data_0, we_1, addr_1, data_1);
endinterface

// File: src/control_unit.sv
//////////////////////////////////////////////////
// Opcode decoder and WAIT stall counter
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_macros.svh"

module control_unit
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  opcode_e                opcode,
	input  logic                   x_bit,
	input  logic [`CPU_WAIT_W-1:0] wait_time,
	output ctrl_t                  ctrl,
	output logic                   stall_control
);

	logic                   wait_active;
	logic [`CPU_WAIT_W-1:0] wait_count;

	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_ADD, OP_SUB: begin
				ctrl.alu_to_reg = 1'b1;
				ctrl.we_dst_0   = 1'b1;
				ctrl.z_we       = 1'b1;
				ctrl.n_we       = 1'b1;
				ctrl.v_we       = 1'b1;
			end
			OP_AND, OP_OR, OP_SLL: begin
				ctrl.alu_to_reg = 1'b1;
				ctrl.we_dst_0   = 1'b1;
				ctrl.z_we       = 1'b1;
				ctrl.n_we       = 1'b1;
			end
			OP_SR: begin
				ctrl.alu_to_reg = 1'b1;
				ctrl.we_dst_0   = 1'b1;
				ctrl.z_we       = 1'b1;
				// Logical right shift leaves N alone
				ctrl.n_we       = x_bit;
			end
			OP_ADDI: begin
				ctrl.alu_to_reg = 1'b1;
				ctrl.we_dst_0   = 1'b1;
				ctrl.add_immd   = 1'b1;
				ctrl.z_we       = 1'b1;
				ctrl.n_we       = 1'b1;
				ctrl.v_we       = 1'b1;
			end
			OP_LDL, OP_LDU: begin
				ctrl.imm_to_reg = 1'b1;
				ctrl.we_dst_0   = 1'b1;
				ctrl.ldl        = (opcode == OP_LDL);
				ctrl.ldu        = (opcode == OP_LDU);
			end
			OP_LD: begin
				ctrl.mem_to_reg = 1'b1;
				ctrl.mem_re     = 1'b1;
				ctrl.we_dst_0   = 1'b1;
			end
			OP_ST:   ctrl.mem_we = 1'b1;
			OP_B:    ctrl.branch = 1'b1;
			OP_J, OP_JI: begin
				ctrl.jump       = 1'b1;
				ctrl.jump_immd  = (opcode == OP_JI);
				ctrl.pcr_to_reg = 1'b1;
				ctrl.we_dst_1   = 1'b1;
			end
			OP_HLT:  ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// WAIT holds the pipeline for wait_time cycles
	//////////////////////////////////////////////////
	always_comb begin
		if (opcode != OP_WAIT)
			stall_control = 1'b0;
		else if (wait_active)
			stall_control = (wait_count != '0);
		else
			stall_control = (wait_time != '0);
	end

	// First stall cycle loads n-1, the rest count down
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wait_active <= 1'b0;
			wait_count  <= '0;
		end else if (!stall_control) begin
			wait_active <= 1'b0;
		end else if (!wait_active) begin
			wait_active <= 1'b1;
			wait_count  <= wait_time - 1'b1;
		end else begin
			wait_count <= wait_count - 1'b1;
		end
	end

endmodule

// File: src/register_file.sv
//////////////////////////////////////////////////
// 32 x 16 register file, 2 read and 2 write ports
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_macros.svh"

module register_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`CPU_REG_AW-1:0] read_addr_0,
	input  logic [`CPU_REG_AW-1:0] read_addr_1,
	output logic [`CPU_DATA_W-1:0] read_data_0,
	output logic [`CPU_DATA_W-1:0] read_data_1,
	wb_if.sink                     wb
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_REG_N];

	// Port 1 is written last so it wins on a shared address
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_REG_N; i++)
				regs[i] <= '0;
		end else begin
			if (wb.we_0)
				regs[wb.addr_0] <= wb.data_0;
			if (wb.we_1)
				regs[wb.addr_1] <= wb.data_1;
		end
	end

	// R0 is hardwired to zero
	assign read_data_0 = (read_addr_0 == '0) ? '0 : regs[read_addr_0];
	assign read_data_1 = (read_addr_1 == '0) ? '0 : regs[read_addr_1];

endmodule

// File: src/alu.sv
//////////////////////////////////////////////////
// ALU with Z/N/V flag outputs
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_macros.svh"

module alu
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic [`CPU_DATA_W-1:0] op0,
	input  logic [`CPU_DATA_W-1:0] op1,
	input  alu_op_e                alu_op,
	input  logic [3:0]             shamt,
	input  logic                   x_bit,
	output logic [`CPU_DATA_W-1:0] result,
	output flags_t                 flags
);

	localparam int MSB = `CPU_DATA_W - 1;

	always_comb begin
		flags.v = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				result  = op0 + op1;
				// Same-sign operands, result sign flipped
				flags.v = (op0[MSB] == op1[MSB]) && (result[MSB] != op0[MSB]);
			end
			ALU_SUB: begin
				result  = op0 - op1;
				flags.v = (op0[MSB] != op1[MSB]) && (result[MSB] != op0[MSB]);
			end
			ALU_AND: result = op0 & op1;
			ALU_OR:  result = op0 | op1;
			ALU_SLL: result = op0 << shamt;
			ALU_SR: begin
				// x_bit picks arithmetic over logical
				if (x_bit)
					result = $unsigned($signed(op0) >>> shamt);
				else
					result = op0 >> shamt;
			end
			default: result = op0;
		endcase
	end

	assign flags.z = (result == '0);
	assign flags.n = result[MSB];

endmodule

// File: src/branch_unit.sv
//////////////////////////////////////////////////
// Branch condition check and next-PC select
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_macros.svh"

module branch_unit
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                   branch,
	input  logic                   jump,
	input  cond_e                  cond,
	input  flags_t                 flags,
	input  logic [`CPU_DATA_W-1:0] pc_plus_1,
	input  logic [`CPU_DATA_W-1:0] branch_offset,
	input  logic [`CPU_DATA_W-1:0] jump_target,
	output logic                   pc_select,
	output logic [`CPU_DATA_W-1:0] pc_next,
	output logic [`CPU_DATA_W-1:0] pc_return
);

	logic taken;

	always_comb begin
		case (cond)
			COND_EQ: taken = flags.z;
			COND_NE: taken = !flags.z;
			COND_GT: taken = !flags.z && !flags.n;
			COND_LT: taken = flags.n;
			COND_GE: taken = !flags.n;
			COND_LE: taken = flags.z || flags.n;
			COND_OV: taken = flags.v;
			default: taken = 1'b1;
		endcase
	end

	assign pc_select = jump || (branch && taken);
	// Branches are PC relative, jumps absolute
	assign pc_next   = jump ? jump_target : pc_plus_1 + branch_offset;
	assign pc_return = pc_plus_1;

endmodule

// File: src/decode_execute.sv
//////////////////////////////////////////////////
// Decode-execute stage: register read, ALU, flags,
// branches, hazard bubble and DEX register
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_macros.svh"

module decode_execute
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  instr_t                 instr,
	input  logic [`CPU_DATA_W-1:0] pc_plus_1,
	output logic                   stall,
	output logic                   pc_select,
	output logic [`CPU_DATA_W-1:0] pc_next,
	dex_if.stage                   dex,
	wb_if.sink                     wb
);

	localparam int DW = `CPU_DATA_W;

	logic [DW-1:0]          instr_bits;
	ctrl_t                  ctrl;
	ctrl_t                  ctrl_next;
	logic                   stall_control;
	logic                   hazard;
	logic                   bubble;
	logic                   reads_0;
	logic                   reads_1;
	logic [`CPU_REG_AW-1:0] read_addr_0;
	logic [`CPU_REG_AW-1:0] read_addr_1;
	logic [`CPU_REG_AW-1:0] dst_addr_1;
	logic [DW-1:0]          reg_data_0;
	logic [DW-1:0]          reg_data_1;
	logic [DW-1:0]          alu_op1;
	logic [DW-1:0]          alu_result;
	flags_t                 alu_flags;
	flags_t                 flags_q;
	logic [DW-1:0]          branch_offset;
	logic [DW-1:0]          jump_target;
	logic [DW-1:0]          pc_return;
	logic [DW-1:0]          load_immd;

	// True when the bundle in DEX will write this register
	function automatic logic pending(input logic [`CPU_REG_AW-1:0] addr);
		return (dex.ctrl.we_dst_0 && addr == dex.dst_addr_0) ||
			(dex.ctrl.we_dst_1 && addr == dex.dst_addr_1);
	endfunction

	assign instr_bits = instr;

	control_unit i_control_unit (
		.clk           (clk),
		.rst_n         (rst_n),
		.opcode        (instr.opcode),
		.x_bit         (instr.x_bit),
		.wait_time     (instr_bits[`CPU_WAIT_W-1:0]),
		.ctrl          (ctrl),
		.stall_control (stall_control)
	);

	//////////////////////////////////////////////////
	// Operands
	//////////////////////////////////////////////////
	// LDL and LDU name R0..R7 in bits 10..8
	assign read_addr_0 = (ctrl.ldl || ctrl.ldu) ? {2'b00, instr_bits[10:8]} : instr.rd;
	assign read_addr_1 = instr.rt;

	register_file i_register_file (
		.clk         (clk),
		.rst_n       (rst_n),
		.read_addr_0 (read_addr_0),
		.read_addr_1 (read_addr_1),
		.read_data_0 (reg_data_0),
		.read_data_1 (reg_data_1),
		.wb          (wb)
	);

	assign alu_op1 = ctrl.add_immd ? {{(DW-5){instr.rt[4]}}, instr.rt} : reg_data_1;

	alu i_alu (
		.op0    (reg_data_0),
		.op1    (alu_op1),
		.alu_op (alu_op_e'(instr_bits[13:11])),
		.shamt  (instr.rt[3:0]),
		.x_bit  (instr.x_bit),
		.result (alu_result),
		.flags  (alu_flags)
	);

	// Flags only move when the instruction really retires
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags_q <= '0;
		end else if (!stall) begin
			if (ctrl.z_we)
				flags_q.z <= alu_flags.z;
			if (ctrl.n_we)
				flags_q.n <= alu_flags.n;
			if (ctrl.v_we)
				flags_q.v <= alu_flags.v;
		end
	end

	assign branch_offset = {{(DW-8){instr_bits[7]}}, instr_bits[7:0]};
	assign jump_target   = ctrl.jump_immd ? {{(DW-11){1'b0}}, instr_bits[10:0]} : reg_data_1;

	branch_unit i_branch_unit (
		.branch        (ctrl.branch),
		.jump          (ctrl.jump),
		.cond          (cond_e'(instr_bits[10:8])),
		.flags         (flags_q),
		.pc_plus_1     (pc_plus_1),
		.branch_offset (branch_offset),
		.jump_target   (jump_target),
		.pc_select     (pc_select),
		.pc_next       (pc_next),
		.pc_return     (pc_return)
	);

	// Byte merge for LDL and LDU
	assign load_immd  = ctrl.ldu ? {instr_bits[7:0], reg_data_0[7:0]} :
		{reg_data_0[15:8], instr_bits[7:0]};
	assign dst_addr_1 = ctrl.jump ? `CPU_REG_AW'(`CPU_LINK_REG) : read_addr_1;

	//////////////////////////////////////////////////
	// Hazard and stall
	//////////////////////////////////////////////////
	assign reads_0 = ctrl.alu_to_reg || ctrl.imm_to_reg || ctrl.mem_we;
	assign reads_1 = (ctrl.alu_to_reg && !ctrl.add_immd) || ctrl.mem_re ||
		ctrl.mem_we || (ctrl.jump && !ctrl.jump_immd);
	assign hazard  = (reads_0 && pending(read_addr_0)) || (reads_1 && pending(read_addr_1));
	// A halt in DEX keeps inserting bubbles
	assign bubble  = hazard || dex.ctrl.halt;
	assign stall   = stall_control || bubble;

	always_comb begin
		ctrl_next = ctrl;
		if (bubble) begin
			ctrl_next      = '0;
			ctrl_next.halt = dex.ctrl.halt;
		end
	end

	//////////////////////////////////////////////////
	// DEX pipeline register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n)
			dex.ctrl <= '0;
		else if (!stall_control)
			dex.ctrl <= ctrl_next;
	end

	always_ff @(posedge clk) begin
		if (!stall_control) begin
			dex.dst_addr_0 <= read_addr_0;
			dex.dst_addr_1 <= dst_addr_1;
			dex.alu_result <= alu_result;
			dex.pc_return  <= pc_return;
			dex.mem_addr   <= reg_data_1;
			dex.mem_wdata  <= reg_data_0;
			dex.load_immd  <= load_immd;
			dex.reg_data_0 <= reg_data_0;
		end
	end

endmodule

// File: src/memory_writeback.sv
//////////////////////////////////////////////////
// Memory-writeback stage and halt latch
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_macros.svh"

module memory_writeback (
	input  logic                   clk,
	input  logic                   rst_n,
	dex_if.sink                    dex,
	wb_if.source                   wb,
	output logic [`CPU_DATA_W-1:0] mem_addr,
	output logic [`CPU_DATA_W-1:0] mem_wdata,
	output logic                   mem_we,
	output logic                   mem_re,
	input  logic [`CPU_DATA_W-1:0] mem_rdata,
	output logic                   halted
);

	assign mem_addr  = dex.mem_addr;
	assign mem_wdata = dex.mem_wdata;
	assign mem_we    = dex.ctrl.mem_we;
	assign mem_re    = dex.ctrl.mem_re;

	// Port 0 carries loads, byte loads and ALU results
	assign wb.we_0   = dex.ctrl.we_dst_0;
	assign wb.addr_0 = dex.dst_addr_0;
	assign wb.data_0 = dex.ctrl.mem_to_reg ? mem_rdata :
		dex.ctrl.imm_to_reg ? dex.load_immd : dex.alu_result;

	// Port 1 carries the link value into R16
	assign wb.we_1   = dex.ctrl.we_dst_1;
	assign wb.addr_1 = dex.dst_addr_1;
	assign wb.data_1 = dex.ctrl.pcr_to_reg ? dex.pc_return : dex.reg_data_0;

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (!rst_n)
			halted <= 1'b0;
		else if (dex.ctrl.halt)
			halted <= 1'b1;
	end

endmodule

// File: src/cpu_core.sv
//////////////////////////////////////////////////
// Core top level with PC register and stages
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_core (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic [`CPU_DATA_W-1:0] pc,
	input  logic [`CPU_DATA_W-1:0] instr,
	output logic [`CPU_DATA_W-1:0] mem_addr,
	output logic [`CPU_DATA_W-1:0] mem_wdata,
	output logic                   mem_we,
	output logic                   mem_re,
	input  logic [`CPU_DATA_W-1:0] mem_rdata,
	output logic                   halted
);

	logic                   stall;
	logic                   pc_select;
	logic [`CPU_DATA_W-1:0] pc_next;
	logic [`CPU_DATA_W-1:0] pc_plus_1;

	dex_if dex_bus ();
	wb_if  wb_bus ();

	//////////////////////////////////////////////////
	// Fetch
	//////////////////////////////////////////////////
	assign pc_plus_1 = pc + 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= '0;
		else if (!stall && !halted)
			pc <= pc_select ? pc_next : pc_plus_1;
	end

	decode_execute i_decode_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.instr     (instr),
		.pc_plus_1 (pc_plus_1),
		.stall     (stall),
		.pc_select (pc_select),
		.pc_next   (pc_next),
		.dex       (dex_bus),
		.wb        (wb_bus)
	);

	memory_writeback i_memory_writeback (
		.clk       (clk),
		.rst_n     (rst_n),
		.dex       (dex_bus),
		.wb        (wb_bus),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_we    (mem_we),
		.mem_re    (mem_re),
		.mem_rdata (mem_rdata),
		.halted    (halted)
	);

endmodule

// File: bench/cpu_tb.sv
//////////////////////////////////////////////////
// Core testbench: memories, ISA reference model,
// directed and random programs, store checks
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_tb
	import isa_pkg::*;
;
	typedef logic [31:0] store_q_t[$];
	typedef logic [15:0] addr_q_t[$];

	localparam int WAIT_N = 12;

	logic        clk;
	logic        rst_n;
	logic [15:0] pc;
	logic [15:0] instr;
	logic [15:0] mem_addr;
	logic [15:0] mem_wdata;
	logic        mem_we;
	logic        mem_re;
	logic [15:0] mem_rdata;
	logic        halted;

	logic [15:0] imem [256];
	logic [15:0] dmem [65536];
	logic [15:0] prog[$];
	store_q_t    expected;
	addr_q_t     expected_loads;
	int          store_cycles[$];
	int          cycle;
	int          errors;
	int          tests_run;
	int          tests_failed;
	logic [31:0] exp_store;
	logic [15:0] exp_load;

	cpu_core i_cpu_core (
		.clk       (clk),
		.rst_n     (rst_n),
		.pc        (pc),
		.instr     (instr),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_we    (mem_we),
		.mem_re    (mem_re),
		.mem_rdata (mem_rdata),
		.halted    (halted)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Both memories read combinationally
	assign instr     = imem[pc[7:0]];
	assign mem_rdata = dmem[mem_addr];

	always @(posedge clk) begin
		if (mem_we === 1'b1)
			dmem[mem_addr] <= mem_wdata;
	end

	always @(negedge clk)
		cycle <= cycle + 1;

	//////////////////////////////////////////////////
	// Store and load compare
	//////////////////////////////////////////////////
	always @(posedge clk) begin
		if (rst_n && mem_we === 1'b1) begin
			store_cycles.push_back(cycle);
			assert (expected.size() > 0) else begin
				errors++;
				$display("Unexpected extra store at %0t to address %h", $time, mem_addr);
			end
			if (expected.size() > 0) begin
				exp_store = expected.pop_front();
				assert ({mem_addr, mem_wdata} === exp_store) else begin
					errors++;
					$display("Error at %0t: store to %h data %h, expected %h data %h",
						$time, mem_addr, mem_wdata, exp_store[31:16], exp_store[15:0]);
				end
			end
		end
		if (rst_n && mem_re === 1'b1) begin
			assert (expected_loads.size() > 0) else begin
				errors++;
				$display("Unexpected extra load at %0t from address %h", $time, mem_addr);
			end
			if (expected_loads.size() > 0) begin
				exp_load = expected_loads.pop_front();
				assert (mem_addr === exp_load) else begin
					errors++;
					$display("Error at %0t: load from %h, expected %h",
						$time, mem_addr, exp_load);
				end
			end
		end
	end

	// Untouched data words
	function automatic logic [15:0] fill_word(input logic [15:0] addr);
		return addr ^ 16'h5a3c;
	endfunction

	function automatic logic [15:0] reg_instr(input opcode_e op, input logic x,
		input logic [4:0] rd, input logic [4:0] rt);
		return {op, x, rd, rt};
	endfunction

	// LDL, LDU and B layout
	function automatic logic [15:0] byte_instr(input opcode_e op, input logic [2:0] f,
		input logic [7:0] imm);
		return {op, f, imm};
	endfunction

	function automatic logic [15:0] long_instr(input opcode_e op, input logic [10:0] v);
		return {op, v};
	endfunction

	//////////////////////////////////////////////////
	// ISA-level reference for stores and load addresses
	//////////////////////////////////////////////////
	function automatic store_q_t reference_stores(output addr_q_t loads);
		logic [15:0] r [32];
		logic [15:0] mem [logic [15:0]];
		store_q_t    q;
		logic [15:0] w;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [15:0] pc_r;
		logic [15:0] next;
		logic [2:0]  idx;
		logic        z;
		logic        n;
		logic        v;
		logic        taken;
		logic        done;
		int          steps;
		loads.delete();
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		z = 0;
		n = 0;
		v = 0;
		pc_r = '0;
		done = 0;
		steps = 0;
		while (!done && steps < 4000) begin
			w = imem[pc_r[7:0]];
			a = r[w[9:5]];
			b = r[w[4:0]];
			next = pc_r + 1;
			idx = w[10:8];
			case (opcode_e'(w[15:11]))
				OP_ADD, OP_ADDI: begin
					if (w[15:11] == OP_ADDI)
						b = {{11{w[4]}}, w[4:0]};
					res = a + b;
					v = (a[15] == b[15]) && (res[15] != a[15]);
					z = (res == 0);
					n = res[15];
					r[w[9:5]] = res;
				end
				OP_SUB: begin
					res = a - b;
					v = (a[15] != b[15]) && (res[15] != a[15]);
					z = (res == 0);
					n = res[15];
					r[w[9:5]] = res;
				end
				OP_AND, OP_OR, OP_SLL: begin
					if (w[15:11] == OP_AND)
						res = a & b;
					else if (w[15:11] == OP_OR)
						res = a | b;
					else
						res = a << w[3:0];
					z = (res == 0);
					n = res[15];
					r[w[9:5]] = res;
				end
				OP_SR: begin
					res = w[10] ? $unsigned($signed(a) >>> w[3:0]) : a >> w[3:0];
					z = (res == 0);
					// N only moves on the arithmetic shift
					if (w[10])
						n = res[15];
					r[w[9:5]] = res;
				end
				OP_LDL: r[idx] = {r[idx][15:8], w[7:0]};
				OP_LDU: r[idx] = {w[7:0], r[idx][7:0]};
				OP_LD: begin
					loads.push_back(b);
					r[w[9:5]] = mem.exists(b) ? mem[b] : fill_word(b);
				end
				OP_ST: begin
					q.push_back({b, a});
					mem[b] = a;
				end
				OP_B: begin
					case (idx)
						3'd0:    taken = z;
						3'd1:    taken = !z;
						3'd2:    taken = !z && !n;
						3'd3:    taken = n;
						3'd4:    taken = !n;
						3'd5:    taken = z || n;
						3'd6:    taken = v;
						default: taken = 1;
					endcase
					if (taken)
						next = pc_r + 1 + {{8{w[7]}}, w[7:0]};
				end
				OP_J, OP_JI: begin
					next = (w[15:11] == OP_JI) ? {5'b0, w[10:0]} : b;
					r[`CPU_LINK_REG] = pc_r + 1;
				end
				OP_HLT:  done = 1;
				default: ;
			endcase
			r[0] = '0;
			pc_r = next;
			steps++;
		end
		return q;
	endfunction

	task automatic emit(input logic [15:0] w);
		prog.push_back(w);
	endtask

	// Skipped marker R3, landing marker R4, both stored at R2
	task automatic branch_case(input logic [2:0] cond);
		emit(byte_instr(OP_B, cond, 8'd1));
		emit(reg_instr(OP_ST, 0, 5'd3, 5'd2));
		emit(reg_instr(OP_ST, 0, 5'd4, 5'd2));
	endtask

	//////////////////////////////////////////////////
	// Run one program through reset to halt
	//////////////////////////////////////////////////
	// A nonzero min_gap is the least spacing in cycles of the last two stores
	task automatic run_test(input string name, input int min_gap);
		int start_errors;
		int waited;
		start_errors = errors;
		tests_run++;
		for (int i = 0; i < 256; i++)
			imem[i] = (i < prog.size()) ? prog[i] : long_instr(OP_HLT, 11'(i));
		for (int i = 0; i < 65536; i++)
			dmem[i] = fill_word(16'(i));
		expected = reference_stores(expected_loads);
		store_cycles.delete();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		waited = 0;
		while (halted !== 1'b1 && waited < 2000) begin
			@(negedge clk);
			waited++;
		end
		assert (halted === 1'b1) else begin
			errors++;
			$display("Core never halted in %s after %0d cycles", name, waited);
		end
		if (halted === 1'b1) begin
			repeat (3) @(negedge clk);
			assert (halted === 1'b1) else begin
				errors++;
				$display("Halted dropped again in %s", name);
			end
		end
		assert (expected.size() == 0) else begin
			errors++;
			$display("%0d expected stores never happened in %s", expected.size(), name);
		end
		assert (expected_loads.size() == 0) else begin
			errors++;
			$display("%0d expected loads never happened in %s", expected_loads.size(),
				name);
		end
		if (min_gap > 0) begin
			assert (store_cycles.size() >= 2 &&
				store_cycles[$] - store_cycles[$-1] >= min_gap)
			else begin
				errors++;
				$display("Store after WAIT came too early or went missing in %s", name);
			end
		end
		if (errors == start_errors) begin
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: fail, %0d errors", name, errors - start_errors);
		end
		prog.delete();
	endtask

	initial begin
		rst_n = 1'b0;
		cycle = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(78719));

		// ALU register operations and ADDI
		emit(byte_instr(OP_LDL, 3'd1, 8'h34));
		emit(byte_instr(OP_LDU, 3'd1, 8'h92));
		emit(byte_instr(OP_LDL, 3'd2, 8'h0f));
		emit(byte_instr(OP_LDL, 3'd4, 8'h40));
		for (int k = 0; k < 6; k++) begin
			emit(reg_instr(opcode_e'(k), 0, 5'd1, (k >= 4) ? 5'd3 : 5'd2));
			emit(reg_instr(OP_ST, 0, 5'd1, 5'd4));
		end
		emit(reg_instr(OP_SR, 1, 5'd1, 5'd2));
		emit(reg_instr(OP_ST, 0, 5'd1, 5'd4));
		emit(reg_instr(OP_ADDI, 0, 5'd1, 5'h1d));
		emit(reg_instr(OP_ADDI, 0, 5'd4, 5'd1));
		emit(reg_instr(OP_ST, 0, 5'd1, 5'd4));
		emit(long_instr(OP_HLT, 0));
		run_test("alu ops", 0);

		// Byte loads build constants
		emit(byte_instr(OP_LDL, 3'd5, 8'hcd));
		emit(byte_instr(OP_LDU, 3'd5, 8'hab));
		emit(byte_instr(OP_LDL, 3'd6, 8'h80));
		emit(reg_instr(OP_ST, 0, 5'd5, 5'd6));
		emit(byte_instr(OP_LDU, 3'd5, 8'h01));
		emit(reg_instr(OP_ST, 0, 5'd5, 5'd6));
		emit(long_instr(OP_HLT, 0));
		run_test("byte loads", 0);

		// Store, load back, dependent add
		emit(byte_instr(OP_LDL, 3'd1, 8'h77));
		emit(byte_instr(OP_LDL, 3'd2, 8'h50));
		emit(reg_instr(OP_ST, 0, 5'd1, 5'd2));
		emit(reg_instr(OP_LD, 0, 5'd3, 5'd2));
		emit(reg_instr(OP_ADD, 0, 5'd3, 5'd1));
		emit(reg_instr(OP_ST, 0, 5'd3, 5'd2));
		emit(byte_instr(OP_LDL, 3'd7, 8'h99));
		emit(reg_instr(OP_LD, 0, 5'd8, 5'd7));
		emit(reg_instr(OP_ST, 0, 5'd8, 5'd2));
		emit(long_instr(OP_HLT, 0));
		run_test("load store hazard", 0);

		// Branches on Z, then N, then V
		emit(byte_instr(OP_LDL, 3'd2, 8'h60));
		emit(byte_instr(OP_LDL, 3'd3, 8'ha1));
		emit(byte_instr(OP_LDL, 3'd4, 8'hb2));
		emit(byte_instr(OP_LDL, 3'd1, 8'h01));
		emit(reg_instr(OP_SUB, 0, 5'd1, 5'd1));
		branch_case(3'd0);
		branch_case(3'd1);
		branch_case(3'd5);
		branch_case(3'd4);
		emit(reg_instr(OP_ADDI, 0, 5'd6, 5'h1f));
		branch_case(3'd3);
		branch_case(3'd2);
		branch_case(3'd4);
		emit(byte_instr(OP_LDU, 3'd7, 8'h7f));
		emit(byte_instr(OP_LDL, 3'd7, 8'hff));
		emit(reg_instr(OP_ADDI, 0, 5'd7, 5'd1));
		branch_case(3'd6);
		branch_case(3'd7);
		emit(reg_instr(OP_ADDI, 0, 5'd1, 5'd1));
		branch_case(3'd6);
		branch_case(3'd2);
		emit(long_instr(OP_HLT, 0));
		run_test("branches", 0);

		// Jumps link into R16; word indices matter here
		emit(byte_instr(OP_LDL, 3'd2, 8'h70));
		emit(long_instr(OP_JI, 11'd4));
		emit(reg_instr(OP_ST, 0, 5'd2, 5'd2));
		emit(long_instr(OP_HLT, 0));
		emit(reg_instr(OP_ST, 0, 5'd16, 5'd2));
		emit(byte_instr(OP_LDL, 3'd5, 8'd8));
		emit(reg_instr(OP_J, 0, 5'd0, 5'd5));
		emit(long_instr(OP_HLT, 0));
		emit(reg_instr(OP_ST, 0, 5'd16, 5'd2));
		emit(long_instr(OP_NOP, 0));
		emit(long_instr(OP_WAIT, 11'(WAIT_N)));
		emit(reg_instr(OP_ST, 0, 5'd2, 5'd2));
		emit(long_instr(OP_HLT, 0));
		run_test("jumps and wait", WAIT_N);

		// Random straight-line programs
		for (int t = 0; t < 20; t++) begin
			for (int i = 0; i < 30; i++) begin
				case ($urandom_range(0, 8))
					0, 1, 2, 3, 4, 5:
						emit(reg_instr(opcode_e'($urandom_range(0, 5)), 1'($urandom),
							5'($urandom), 5'($urandom)));
					6: emit(reg_instr(OP_ADDI, 0, 5'($urandom), 5'($urandom)));
					7: emit(byte_instr($urandom_range(0, 1) ? OP_LDU : OP_LDL,
						3'($urandom), 8'($urandom)));
					default: emit(reg_instr(OP_ST, 0, 5'($urandom), 5'($urandom)));
				endcase
			end
			emit(long_instr(OP_HLT, 0));
			run_test($sformatf("random program %0d", t), 0);
		end

		$display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
			errors);
		if (errors == 0 && tests_failed == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: flist.f
+incdir+include
src/isa_pkg.sv
src/pipe_pkg.sv
src/cpu_ifs.sv
src/control_unit.sv
src/register_file.sv
src/alu.sv
src/branch_unit.sv
src/decode_execute.sv
src/memory_writeback.sv
src/cpu_core.sv
bench/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - include
    files:
      - src/isa_pkg.sv
      - src/pipe_pkg.sv
      - src/cpu_ifs.sv
      - src/control_unit.sv
      - src/register_file.sv
      - src/alu.sv
      - src/branch_unit.sv
      - src/decode_execute.sv
      - src/memory_writeback.sv
      - src/cpu_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/cpu_tb.sv
